//--- bench/tb_clock.sv
module tb_clock #(
  parameter int period = 40
) (
  output logic dostring_clk
);

  // free-running clock, low for the first half period
  initial
  begin
    dostring_clk = 1'b0;
    forever #(period / 2) dostring_clk = ~dostring_clk;
  end

endmodule

//--- bench/wave_input.txt
# op and arguments in decimal, the frame word in hex: W addr data | R addr expect | I cycles
# A string frame | F string frame kind word | C string base white | M first last base white | E test
R 0 0
R 4 150
R 8 3
R 12 0
I 200
E reset_idle
W 0 1
C 0 3 150
C 1 3 150
E string_framing
F 0 0 0 00000000
F 0 1 1 ffc80000
F 0 22 1 ffc80000
F 0 23 1 ff969696
F 0 24 1 ff00c800
F 0 47 1 ff00c800
F 0 48 2 ffffffff
E zones_string0
A 2 10
R 12 2
W 4 90
W 8 5
R 4 90
R 8 5
F 2 29 1 ff5a5a5a
C 3 5 90
A 4 10
R 12 4
E register_steering
F 30 1 1 ff00c800
F 30 5 1 ff5a5a5a
F 30 6 1 ff0000c8
C 30 5 90
E phase_rotation
M 4 40 5 90
E trace_motion

//--- bench/wave_tb.sv
module wave_tb;
  import wand_pkg::*;

  localparam int PERIOD = 40;
  localparam int DRIVE_DELAY = 5;
  // these match the default parameters of the DUT
  localparam int STRING_LEN = 47;
  localparam int SCK_DIV = 2;
  localparam int FRAMES = STRING_LEN + 2;
  localparam int MAX_STRINGS = 62;
  localparam int MAX_WORDS = MAX_STRINGS * FRAMES;
  // every frame is 64 sck levels of SCK_DIV clocks, plus a fifth for margin
  localparam longint WATCHDOG_TIME = longint'(MAX_WORDS) * 64 * SCK_DIV * PERIOD * 12 / 10;

  logic dostring_clk;
  logic dostring_reset;
  logic psel;
  logic penable;
  logic pwrite;
  logic [3:0] paddr;
  logic [7:0] pwdata;
  logic [7:0] prdata;
  logic mosi;
  logic sck;

  // words seen on the SPI link, in arrival order
  logic [31:0] frame_words [0:MAX_WORDS-1];
  logic [31:0] shift_in = '0;
  int bit_count = 0;
  int word_count = 0;

  int errors = 0;
  int checks = 0;
  int test_errors = 0;
  int tests = 0;
  int failed_tests = 0;

  tb_clock #(.period(PERIOD)) u_tb_clock (.dostring_clk(dostring_clk));

  dostring_wave u_dostring_wave (
    .dostring_clk(dostring_clk), .dostring_reset(dostring_reset),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata), .mosi(mosi), .sck(sck)
  );

  // mosi is settled on every rising sck, so bits are collected there, 32 to a word
  always @(posedge sck)
  begin
    shift_in = {shift_in[30:0], mosi};
    bit_count = bit_count + 1;
    if (bit_count == 32)
    begin
      if (word_count < MAX_WORDS)
        frame_words[word_count] = shift_in;
      word_count = word_count + 1;
      bit_count = 0;
    end
  end

  // zero wait state write, the data lands on the edge that closes the access phase
  task automatic apb_write(input logic [3:0] addr, input logic [7:0] data);
    @(posedge dostring_clk);
    #DRIVE_DELAY;
    psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b1;
    paddr = addr;
    pwdata = data;
    @(posedge dostring_clk);
    #DRIVE_DELAY;
    penable = 1'b1;
    @(posedge dostring_clk);
    #DRIVE_DELAY;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  // prdata is combinational, so it is taken mid-cycle during the access phase
  task automatic apb_read(input logic [3:0] addr, output logic [7:0] data);
    @(posedge dostring_clk);
    #DRIVE_DELAY;
    psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = addr;
    @(posedge dostring_clk);
    #DRIVE_DELAY;
    penable = 1'b1;
    @(negedge dostring_clk);
    data = prdata;
    @(posedge dostring_clk);
    #DRIVE_DELAY;
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic check_reg(input logic [7:0] got, input logic [7:0] exp, input string what);
    checks++;
    if (got !== exp)
    begin
      $display("Fail at %0t: %s read %0d, expected %0d", $time, what, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_kind(input frame_kind_t got, input frame_kind_t exp, input string what);
    checks++;
    if (got !== exp)
    begin
      $display("Fail at %0t: %s has kind %0d, expected %0d", $time, what, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_color(input color_t got, input color_t exp, input string what);
    checks++;
    if (got !== exp)
    begin
      $display("Fail at %0t: %s carries b/g/r %0d/%0d/%0d, expected %0d/%0d/%0d", $time,
               what, got.blue, got.green, got.red, exp.blue, exp.green, exp.red);
      errors++;
      test_errors++;
    end
  endtask

  // all zeros opens a string, all ones closes it, and an LED word starts with 8'hFF
  function automatic frame_kind_t kind_of(input logic [31:0] word);
    if (word == 32'h0000_0000)
      return kind_start;
    if (word == 32'hFFFF_FFFF)
      return kind_end;
    if (word[31:24] == 8'hFF)
      return kind_led;
    // a word that fits no kind gets the unused code so that no expectation matches
    return frame_kind_t'(2'd3);
  endfunction

  // a colour steps zero, ascend, descend and back once every 30 strings
  function automatic phase_t phase_at(input phase_t first, input int s);
    int steps;
    phase_t p;
    steps = (s / COLOR_STAGE_LEN) % 3;
    p = first;
    repeat (steps)
    begin
      case (p)
        phase_zero:
          p = phase_ascend;
        phase_ascend:
          p = phase_descend;
        default:
          p = phase_zero;
      endcase
    end
    return p;
  endfunction

  function automatic logic [7:0] level_for(input phase_t p, input int stage);
    if (p == phase_ascend)
      return COLOR_TABLE[ASCEND_BASE + stage];
    if (p == phase_descend)
      return COLOR_TABLE[DESCEND_BASE + stage];
    return 8'd0;
  endfunction

  // the LED at the trace is white, the handle side shows the top rainbow
  function automatic color_t expected_color(input int s, input int led, input int base,
                                            input logic [7:0] white);
    int pos;
    int stage;
    color_t c;
    pos = base + WAND_TABLE[s % WAND_STEPS];
    stage = s % COLOR_STAGE_LEN;
    if (led == pos)
    begin
      c.blue = white;
      c.green = white;
      c.red = white;
    end
    else if (led < pos)
    begin
      c.blue = level_for(phase_at(phase_descend, s), stage);
      c.green = level_for(phase_at(phase_ascend, s), stage);
      c.red = level_for(phase_at(phase_zero, s), stage);
    end
    else
    begin
      c.blue = level_for(phase_at(phase_zero, s), stage);
      c.green = level_for(phase_at(phase_descend, s), stage);
      c.red = level_for(phase_at(phase_ascend, s), stage);
    end
    return c;
  endfunction

  // the allowance grows with the number of frames still to come
  task automatic wait_frame(input int idx, output bit arrived);
    int limit;
    int waited;
    limit = (idx + 1 - word_count) * (64 * SCK_DIV + 16) + 200;
    waited = 0;
    arrived = 1'b0;
    if (idx >= MAX_WORDS)
    begin
      $display("error: frame %0d lies beyond the capture buffer", idx);
      errors++;
      test_errors++;
    end
    else
    begin
      while (word_count <= idx && waited < limit)
      begin
        @(posedge dostring_clk);
        waited++;
      end
      arrived = (word_count > idx);
      if (!arrived)
      begin
        $display("error: frame %0d of string %0d never arrived on the SPI link",
                 idx % FRAMES, idx / FRAMES);
        errors++;
        test_errors++;
      end
    end
  endtask

  // every frame of one string against the framing, zone and colour rules
  task automatic check_string(input int s, input int base, input logic [7:0] white);
    int f;
    bit arrived;
    logic [31:0] word;
    frame_kind_t exp_kind;
    string what;
    wait_frame(s * FRAMES + FRAMES - 1, arrived);
    if (arrived)
    begin
      for (f = 0; f < FRAMES; f++)
      begin
        word = frame_words[s * FRAMES + f];
        what = $sformatf("string %0d frame %0d", s, f);
        if (f == 0)
          exp_kind = kind_start;
        else if (f == FRAMES - 1)
          exp_kind = kind_end;
        else
          exp_kind = kind_led;
        check_kind(kind_of(word), exp_kind, what);
        if (exp_kind == kind_led)
          check_color(word[23:0], expected_color(s, f, base, white), what);
      end
    end
  endtask

  // the SPI link must stay quiet while run is clear
  task automatic check_idle(input int cycles);
    int i;
    int busy_cycles;
    busy_cycles = 0;
    for (i = 0; i < cycles; i++)
    begin
      @(negedge dostring_clk);
      if (sck !== 1'b0 || mosi !== 1'b0)
        busy_cycles++;
    end
    checks++;
    if (busy_cycles != 0)
    begin
      $display("Fail at %0t: SPI link active on %0d of %0d idle cycles", $time,
               busy_cycles, cycles);
      errors++;
      test_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    tests++;
    if (test_errors == 0)
      $display("test %s passed", name);
    else
    begin
      $display("test %s failed with %0d errors", name, test_errors);
      failed_tests++;
    end
    test_errors = 0;
  endtask

  // one command per line, lines starting with # are skipped
  task automatic run_script(input int fd);
    string line;
    string op;
    string name;
    int n;
    int a;
    int b;
    int c;
    int d;
    int s;
    bit arrived;
    logic [7:0] data;
    logic [31:0] word;
    while (!$feof(fd))
    begin
      n = $fgets(line, fd);
      if (n == 0)
        break;
      n = $sscanf(line, "%s", op);
      if (n < 1 || op.substr(0, 0) == "#")
        continue;
      if (op == "W")
      begin
        n = $sscanf(line, "%s %d %d", op, a, b);
        apb_write(4'(a), 8'(b));
      end
      else if (op == "R")
      begin
        n = $sscanf(line, "%s %d %d", op, a, b);
        apb_read(4'(a), data);
        check_reg(data, 8'(b), $sformatf("register at address %0d", a));
      end
      else if (op == "I")
      begin
        n = $sscanf(line, "%s %d", op, a);
        check_idle(a);
      end
      else if (op == "A")
      begin
        n = $sscanf(line, "%s %d %d", op, a, b);
        wait_frame(a * FRAMES + b, arrived);
      end
      else if (op == "F")
      begin
        n = $sscanf(line, "%s %d %d %d %h", op, a, b, c, word);
        wait_frame(a * FRAMES + b, arrived);
        if (arrived)
        begin
          check_kind(kind_of(frame_words[a * FRAMES + b]), frame_kind_t'(c),
                     $sformatf("string %0d frame %0d", a, b));
          if (frame_kind_t'(c) == kind_led)
            check_color(frame_words[a * FRAMES + b][23:0], word[23:0],
                        $sformatf("string %0d frame %0d", a, b));
        end
      end
      else if (op == "C")
      begin
        n = $sscanf(line, "%s %d %d %d", op, a, b, c);
        check_string(a, b, 8'(c));
      end
      else if (op == "M")
      begin
        n = $sscanf(line, "%s %d %d %d %d", op, a, b, c, d);
        for (s = a; s <= b; s++)
          check_string(s, c, 8'(d));
      end
      else if (op == "E")
      begin
        n = $sscanf(line, "%s %s", op, name);
        finish_test(name);
      end
      else
      begin
        $display("error: unknown command %s in the stimulus file", op);
        errors++;
      end
    end
  endtask

  initial
  begin : driver
    int fd;
    dostring_reset = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = 4'd0;
    pwdata = 8'd0;
    repeat (3) @(posedge dostring_clk);
    #DRIVE_DELAY;
    dostring_reset = 1'b0;
    fd = $fopen("bench/wave_input.txt", "r");
    if (fd == 0)
    begin
      $display("error: cannot open the stimulus file bench/wave_input.txt");
      errors++;
    end
    else
    begin
      run_script(fd);
      $fclose(fd);
    end
    $display("%0d tests, %0d failed, %0d checks, %0d errors", tests, failed_tests, checks,
             errors);
    if (errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

  // a stalled link would otherwise keep the run going forever
  initial
  begin : watchdog
    #(WATCHDOG_TIME);
    $display("error: the run did not finish within %0d time units", WATCHDOG_TIME);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

//--- rtl/color_phase.sv
module color_phase (
  input  logic             dostring_clk,
  input  logic             dostring_reset,
  input  logic             string_done,
  output wand_pkg::color_t top_color,
  output wand_pkg::color_t bottom_color
);
  import wand_pkg::*;

  // strings already shown in the current phase, 0 to 29
  logic [4:0] stage;

  // phase of each primary colour between the handle and the trace
  phase_t blue_top_phase;
  phase_t green_top_phase;
  phase_t red_top_phase;

  // phase of each primary colour beyond the trace
  phase_t blue_bottom_phase;
  phase_t green_bottom_phase;
  phase_t red_bottom_phase;

  // a colour goes up from zero, then down, then rests at zero
  function automatic phase_t next_phase(input phase_t phase);
    phase_t step;
    case (phase)
      phase_zero:
        step = phase_ascend;
      phase_ascend:
        step = phase_descend;
      default:
        step = phase_zero;
    endcase
    return step;
  endfunction

  // intensity of one colour for the current stage of its phase
  function automatic logic [7:0] phase_level(input phase_t phase, input logic [4:0] at);
    logic [7:0] level;
    case (phase)
      phase_ascend:
        level = COLOR_TABLE[ASCEND_BASE + at];
      phase_descend:
        level = COLOR_TABLE[DESCEND_BASE + at];
      // the zero phase and the unused code both leave the colour dark
      default:
        level = 8'd0;
    endcase
    return level;
  endfunction

  always_ff @(posedge dostring_clk or posedge dostring_reset)
  begin
    if (dostring_reset)
    begin
      stage <= 5'd0;
      // the two rainbows start a third of a cycle apart
      blue_top_phase <= phase_descend;
      green_top_phase <= phase_ascend;
      red_top_phase <= phase_zero;
      green_bottom_phase <= phase_descend;
      blue_bottom_phase <= phase_zero;
      red_bottom_phase <= phase_ascend;
    end
    else if (string_done)
    begin
      if (stage == 5'(COLOR_STAGE_LEN - 1))
      begin
        // end of a phase, every colour moves on together
        stage <= 5'd0;
        blue_top_phase <= next_phase(blue_top_phase);
        green_top_phase <= next_phase(green_top_phase);
        red_top_phase <= next_phase(red_top_phase);
        blue_bottom_phase <= next_phase(blue_bottom_phase);
        green_bottom_phase <= next_phase(green_bottom_phase);
        red_bottom_phase <= next_phase(red_bottom_phase);
      end
      else
      begin
        stage <= stage + 5'd1;
      end
    end
  end

  // both colours hold for a whole string since stage only moves between strings
  assign top_color.blue = phase_level(blue_top_phase, stage);
  assign top_color.green = phase_level(green_top_phase, stage);
  assign top_color.red = phase_level(red_top_phase, stage);
  assign bottom_color.blue = phase_level(blue_bottom_phase, stage);
  assign bottom_color.green = phase_level(green_bottom_phase, stage);
  assign bottom_color.red = phase_level(red_bottom_phase, stage);

  // the ascend lookup reads beyond the table if the stage ever reaches 30
  a_stage_in_range: assert property (
    @(posedge dostring_clk) disable iff (dostring_reset)
    stage < 5'(COLOR_STAGE_LEN)
  );

endmodule

//--- rtl/dostring_wave.sv
module dostring_wave #(
  parameter int string_len = 47,
  parameter int sck_div = 2
) (
  input  logic       dostring_clk,
  input  logic       dostring_reset,
  input  logic       psel,
  input  logic       penable,
  input  logic       pwrite,
  input  logic [3:0] paddr,
  input  logic [7:0] pwdata,
  output logic [7:0] prdata,
  output logic       mosi,
  output logic       sck
);
  import wand_pkg::*;

  logic run;
  logic [7:0] white_level;
  logic [5:0] trace_base;
  logic [5:0] sweep_index;
  logic string_done;
  color_t top_color;
  color_t bottom_color;

  // single frame channel between the sequencer and the SPI serializer
  led_frame_if u_frame ();

  // software sets run, white level and trace offset and reads back the sweep step
  wand_regs u_wand_regs (
    .dostring_clk(dostring_clk), .dostring_reset(dostring_reset),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .sweep_index(sweep_index), .prdata(prdata), .run(run),
    .white_level(white_level), .trace_base(trace_base)
  );

  // the two rainbow colours step once per finished string
  color_phase u_color_phase (
    .dostring_clk(dostring_clk), .dostring_reset(dostring_reset),
    .string_done(string_done), .top_color(top_color), .bottom_color(bottom_color)
  );

  string_sequencer #(.string_len(string_len)) u_string_sequencer (
    .dostring_clk(dostring_clk), .dostring_reset(dostring_reset), .run(run),
    .white_level(white_level), .trace_base(trace_base), .top_color(top_color),
    .bottom_color(bottom_color), .string_done(string_done),
    .sweep_index(sweep_index), .frame(u_frame.sequencer)
  );

  // sck_div sets how many clocks each sck level lasts
  led_spi_tx #(.sck_div(sck_div)) u_led_spi_tx (
    .dostring_clk(dostring_clk), .dostring_reset(dostring_reset),
    .frame(u_frame.serializer), .mosi(mosi), .sck(sck)
  );

endmodule

//--- rtl/led_frame_if.sv
interface led_frame_if;
  import wand_pkg::*;

  // word type for the frame in flight
  frame_kind_t kind;

  // LED colour, only meaningful for kind_led frames
  color_t color;

  // one-cycle request from the sequencer, raised only while busy is low
  logic start;

  // held by the serializer from the cycle after start until the last bit is out
  logic busy;

  // the sequencer owns the frame contents and the request
  modport sequencer (output kind, output color, output start, input busy);

  // the serializer only reads the frame and reports back
  modport serializer (input kind, input color, input start, output busy);

endinterface

//--- rtl/led_spi_tx.sv
module led_spi_tx #(
  parameter int sck_div = 2
) (
  input  logic            dostring_clk,
  input  logic            dostring_reset,
  led_frame_if.serializer frame,
  output logic            mosi,
  output logic            sck
);
  import wand_pkg::*;

  // a divider of one still needs a one-bit counter
  localparam int DIV_W = (sck_div > 1) ? $clog2(sck_div) : 1;
  localparam int BIT_W = $clog2(FRAME_BITS);
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(sck_div - 1);

  logic [FRAME_BITS-1:0] word;
  logic [FRAME_BITS-1:0] shreg;
  logic [DIV_W-1:0] div_cnt;
  logic [BIT_W-1:0] bit_cnt;
  logic half_done;

  // start is all zeros, an LED is header then blue, green, red, and end is all ones
  always_comb
  begin
    case (frame.kind)
      kind_start:
        word = '0;
      kind_led:
        word = {LED_HEADER, frame.color};
      default:
        word = '1;
    endcase
  end

  // one sck level has lasted sck_div clocks
  assign half_done = frame.busy && (div_cnt == DIV_LAST);

  always_ff @(posedge dostring_clk or posedge dostring_reset)
  begin
    if (dostring_reset)
    begin
      frame.busy <= 1'b0;
      sck <= 1'b0;
      div_cnt <= '0;
      bit_cnt <= '0;
    end
    else if (!frame.busy)
    begin
      sck <= 1'b0;
      div_cnt <= '0;
      bit_cnt <= '0;
      frame.busy <= frame.start;
    end
    else if (half_done)
    begin
      div_cnt <= '0;
      sck <= ~sck;
      // every falling edge retires one bit and the 32nd ends the frame
      if (sck)
      begin
        bit_cnt <= bit_cnt + 1'b1;
        if (bit_cnt == BIT_W'(FRAME_BITS - 1))
          frame.busy <= 1'b0;
      end
    end
    else
    begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // mosi moves only together with a falling sck so it is settled for the rising edge
  always_ff @(posedge dostring_clk)
  begin
    if (!frame.busy && frame.start)
      shreg <= word;
    else if (half_done && sck)
      shreg <= {shreg[FRAME_BITS-2:0], 1'b0};
  end

  // the line idles low between frames
  assign mosi = frame.busy && shreg[FRAME_BITS-1];

  // a second request during a frame would be lost, since only one frame is in flight
  a_no_start_while_busy: assert property (
    @(posedge dostring_clk) disable iff (dostring_reset)
    frame.start |-> !frame.busy
  );

endmodule

//--- rtl/string_sequencer.sv
module string_sequencer #(
  parameter int string_len = 47
) (
  input  logic             dostring_clk,
  input  logic             dostring_reset,
  input  logic             run,
  input  logic [7:0]       white_level,
  input  logic [5:0]       trace_base,
  input  wand_pkg::color_t top_color,
  input  wand_pkg::color_t bottom_color,
  output logic             string_done,
  output logic [5:0]       sweep_index,
  led_frame_if.sequencer   frame
);
  import wand_pkg::*;

  // the counter value at which the end frame goes out
  localparam logic [7:0] LAST_COUNT = 8'(string_len + 1);

  // wait for the link, load a frame, request it, then two cycles of bookkeeping
  // and after an end frame two more to advance the wand and the colours
  typedef enum logic [2:0] {
    s_wait, s_load, s_start, s_count, s_check, s_wand, s_phase
  } seq_state_t;

  seq_state_t state;

  // frame position in the string, 0 is the start frame and LAST_COUNT the end frame
  logic [7:0] led_count;

  // step through WAND_TABLE, one per string
  logic [5:0] wand_step;

  // LED index of the white trace, fixed for the whole string
  logic [7:0] trace_pos;

  // zone of the next LED, worked out while the previous one is on the wire
  zone_t zone;

  assign frame.start = (state == s_start);
  assign string_done = (state == s_phase);
  assign sweep_index = wand_step;

  always_ff @(posedge dostring_clk or posedge dostring_reset)
  begin
    if (dostring_reset)
    begin
      state <= s_wait;
      led_count <= 8'd0;
      wand_step <= 6'd0;
      trace_pos <= 8'd0;
      zone <= zone_top;
      frame.kind <= kind_start;
    end
    else
    begin
      case (state)
        s_wait:
          begin
            // run is only sampled at a string boundary so a string always completes
            if (!frame.busy && (led_count != 8'd0 || run))
            begin
              if (led_count == 8'd0)
              begin
                trace_pos <= {2'd0, trace_base} + WAND_TABLE[wand_step];
              end
              state <= s_load;
            end
          end
        s_load:
          begin
            if (led_count == 8'd0)
              frame.kind <= kind_start;
            else if (led_count == LAST_COUNT)
              frame.kind <= kind_end;
            else
              frame.kind <= kind_led;
            state <= s_start;
          end
        s_start:
          state <= s_count;
        s_count:
          begin
            led_count <= (led_count == LAST_COUNT) ? 8'd0 : led_count + 8'd1;
            state <= s_check;
          end
        s_check:
          begin
            // classify against the trace for the LED that goes out next
            if (led_count < trace_pos)
              zone <= zone_top;
            else if (led_count == trace_pos)
              zone <= zone_middle;
            else
              zone <= zone_bottom;
            // a wrapped counter means the end frame was just handed over
            state <= (led_count == 8'd0) ? s_wand : s_wait;
          end
        s_wand:
          begin
            wand_step <= (wand_step == 6'(WAND_STEPS - 1)) ? 6'd0 : wand_step + 6'd1;
            state <= s_phase;
          end
        // string_done is high here and the colour stage moves on this edge
        s_phase:
          state <= s_wait;
        default:
          state <= s_wait;
      endcase
    end
  end

  // colour is loaded with the kind and stays put while the serializer is busy
  always_ff @(posedge dostring_clk)
  begin
    if (state == s_load)
    begin
      if (led_count == 8'd0 || led_count == LAST_COUNT)
        frame.color <= '0;
      else if (zone == zone_middle)
        frame.color <= '{blue: white_level, green: white_level, red: white_level};
      else if (zone == zone_top)
        frame.color <= top_color;
      else
        frame.color <= bottom_color;
    end
  end

endmodule

//--- rtl/wand_pkg.sv
package wand_pkg;

  // one LED colour in wire order, so blue leaves the serializer first
  typedef struct packed {
    logic [7:0] blue;
    logic [7:0] green;
    logic [7:0] red;
  } color_t;

  // the three word types that make up one string on the SPI link
  typedef enum logic [1:0] {kind_start, kind_led, kind_end} frame_kind_t;

  // each primary colour is flat at zero, rising or falling on the sine table
  typedef enum logic [1:0] {phase_zero, phase_ascend, phase_descend} phase_t;

  // where an LED sits relative to the white trace
  typedef enum logic [1:0] {zone_top, zone_middle, zone_bottom} zone_t;

  // a colour phase lasts this many strings
  localparam int COLOR_STAGE_LEN = 30;

  // the rising half of the colour table starts here and the falling half at zero
  localparam int ASCEND_BASE = 30;
  localparam int DESCEND_BASE = 0;

  // the trace position table has this many steps before it repeats
  localparam int WAND_STEPS = 40;

  // every SPI word is this long
  localparam int FRAME_BITS = 32;

  // the LED frame opens with a fixed byte of ones
  localparam logic [7:0] LED_HEADER = 8'hFF;

  // APB register map
  localparam logic [3:0] ADDR_CTRL = 4'd0;
  localparam logic [3:0] ADDR_WHITE = 4'd4;
  localparam logic [3:0] ADDR_BASE = 4'd8;
  localparam logic [3:0] ADDR_STATUS = 4'd12;

  // register values seen after reset
  localparam logic [7:0] WHITE_DEFAULT = 8'd150;
  localparam logic [5:0] BASE_DEFAULT = 6'd3;

  // colour intensity over one full cycle. falls from 200 to 0 and rises again
  localparam logic [7:0] COLOR_TABLE [0:59] = '{
    8'd200, 8'd199, 8'd197, 8'd195, 8'd191, 8'd186, 8'd180, 8'd174, 8'd166, 8'd158,
    8'd150, 8'd140, 8'd130, 8'd120, 8'd110, 8'd100, 8'd89,  8'd79,  8'd69,  8'd59,
    8'd49,  8'd41,  8'd33,  8'd25,  8'd19,  8'd13,  8'd8,   8'd4,   8'd2,   8'd0,
    8'd0,   8'd0,   8'd2,   8'd4,   8'd8,   8'd13,  8'd19,  8'd25,  8'd33,  8'd41,
    8'd49,  8'd59,  8'd69,  8'd79,  8'd89,  8'd100, 8'd110, 8'd120, 8'd130, 8'd140,
    8'd150, 8'd158, 8'd166, 8'd174, 8'd180, 8'd186, 8'd191, 8'd195, 8'd197, 8'd199
  };

  // trace height above the base offset for each step of the sweep
  localparam logic [7:0] WAND_TABLE [0:39] = '{
    8'd20, 8'd23, 8'd26, 8'd29, 8'd31, 8'd34, 8'd36, 8'd37, 8'd39, 8'd39,
    8'd40, 8'd39, 8'd39, 8'd37, 8'd36, 8'd34, 8'd31, 8'd29, 8'd26, 8'd23,
    8'd20, 8'd16, 8'd13, 8'd10, 8'd8,  8'd5,  8'd3,  8'd2,  8'd0,  8'd0,
    8'd0,  8'd0,  8'd0,  8'd2,  8'd3,  8'd5,  8'd8,  8'd10, 8'd13, 8'd16
  };

endpackage

//--- rtl/wand_regs.sv
module wand_regs (
  input  logic       dostring_clk,
  input  logic       dostring_reset,
  input  logic       psel,
  input  logic       penable,
  input  logic       pwrite,
  input  logic [3:0] paddr,
  input  logic [7:0] pwdata,
  input  logic [5:0] sweep_index,
  output logic [7:0] prdata,
  output logic       run,
  output logic [7:0] white_level,
  output logic [5:0] trace_base
);
  import wand_pkg::*;

  logic access;

  // zero wait states, so the access phase is a single cycle with psel and penable high
  assign access = psel && penable;

  // writes land on the access-phase edge
  always_ff @(posedge dostring_clk or posedge dostring_reset)
  begin
    if (dostring_reset)
    begin
      run <= 1'b0;
      white_level <= WHITE_DEFAULT;
      trace_base <= BASE_DEFAULT;
    end
    else if (access && pwrite)
    begin
      case (paddr)
        // bit 0 of the control register lets the sequencer start new strings
        ADDR_CTRL:
          run <= pwdata[0];
        ADDR_WHITE:
          white_level <= pwdata;
        // the trace offset is six bits wide and the upper data bits are ignored
        ADDR_BASE:
          trace_base <= pwdata[5:0];
        // status is read-only and other addresses hold nothing
        default:
          run <= run;
      endcase
    end
  end

  // read data is combinational and only driven during a read access
  always_comb
  begin
    prdata = 8'd0;
    if (access && !pwrite)
    begin
      case (paddr)
        ADDR_CTRL:
          prdata = {7'd0, run};
        ADDR_WHITE:
          prdata = white_level;
        ADDR_BASE:
          prdata = {2'd0, trace_base};
        // status reports which step of the sweep the wand is on
        ADDR_STATUS:
          prdata = {2'd0, sweep_index};
        default:
          prdata = 8'd0;
      endcase
    end
  end

  // the bus master must open a transfer with a setup phase before enabling it
  a_penable_needs_psel: assert property (
    @(posedge dostring_clk) disable iff (dostring_reset)
    $rose(penable) |-> psel
  );

endmodule

//--- verilog.f
rtl/wand_pkg.sv
rtl/led_frame_if.sv
rtl/wand_regs.sv
rtl/color_phase.sv
rtl/string_sequencer.sv
rtl/led_spi_tx.sv
rtl/dostring_wave.sv
bench/tb_clock.sv
bench/wave_tb.sv
